//--- Makefile
VERILATOR ?= verilator
TOP       ?= decodeTb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: sim clean

# Pass is decided by the message in the simulator output
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(BUILD_DIR)

//--- compile.f
verilog/rvDecodePkg.sv
verilog/mainControl.sv
verilog/aluControl.sv
verilog/immediateGen.sv
verilog/registerFile.sv
verilog/idExStage.sv
verilog/decodeTop.sv
verif/decodeTb.sv

//--- verif/decodeTb.sv
`timescale 1ns/10ps

module decodeTb;
    import rvDecodePkg::*;

    localparam int testCycles    = 200; // Rough length of all directed tests
    localparam int timeoutCycles = 10 * testCycles;

    logic       clk;
    logic       reset;
    logic       inValid;
    instrT      instr;
    wordT       pc;
    logic       inReady;
    logic       outReady;
    logic       wbEnable;
    regAddrT    wbAddr;
    wordT       wbData;
    logic       outValid;
    logic       branch;
    logic       memRead;
    logic       memWrite;
    logic       memToReg;
    logic [1:0] aluSrcA;
    logic       aluSrcB;
    logic       regWrite;
    logic [1:0] jump;
    logic       pcPlus4;
    logic       csrEnable;
    logic       exception;
    aluFuncT    aluFunc;
    wordT       imm;
    wordT       rs1Data;
    wordT       rs2Data;
    regAddrT    rd;
    wordT       pcOut;

    logic [12:0] ctrlSeen;
    wordT        regModel [32]; // Expected register contents
    wordT        nextPc;
    integer      seed = 32'h152f6a85;
    int          cycleCount = 0;

    assign ctrlSeen = {branch, memRead, memWrite, memToReg, aluSrcA, aluSrcB, regWrite,
                       jump, pcPlus4, csrEnable, exception};

    decodeTop #(.regCount(32)) i_decodeTop (
        .i_clk(clk), .i_reset(reset), .i_inValid(inValid), .i_instr(instr), .i_pc(pc),
        .o_inReady(inReady), .i_outReady(outReady), .i_wbEnable(wbEnable),
        .i_wbAddr(wbAddr), .i_wbData(wbData), .o_outValid(outValid), .o_branch(branch),
        .o_memRead(memRead), .o_memWrite(memWrite), .o_memToReg(memToReg),
        .o_aluSrcA(aluSrcA), .o_aluSrcB(aluSrcB), .o_regWrite(regWrite), .o_jump(jump),
        .o_pcPlus4(pcPlus4), .o_csrEnable(csrEnable), .o_exception(exception),
        .o_aluFunc(aluFunc), .o_imm(imm), .o_rs1Data(rs1Data), .o_rs2Data(rs2Data),
        .o_rd(rd), .o_pc(pcOut)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > timeoutCycles) begin
            $display("Error: tests did not finish within %0d cycles", timeoutCycles);
            $display("Simulation failed");
            $fatal(1, "Timeout");
        end
    end

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail %s: got %h, expected %h", name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Control table per opcode class
    function automatic logic [12:0] expectedControls(input instrT word);
        logic        envCall;
        logic [12:0] ctrl;
        envCall = (word[19:7] == 13'd0) && (word[31:20] == 12'h000 || word[31:20] == 12'h001);
        // branch memRead memWrite memToReg srcA srcB regWrite jump pcPlus4 csr exception
        case (word[6:0])
            opRType:  ctrl = 13'b0_0_0_0_00_0_1_00_0_0_0;
            opIType:  ctrl = 13'b0_0_0_0_00_1_1_00_0_0_0;
            opLoad:   ctrl = 13'b0_1_0_1_00_1_1_00_0_0_0;
            opStore:  ctrl = 13'b0_0_1_0_00_1_0_00_0_0_0;
            opBranch: ctrl = 13'b1_0_0_0_00_0_0_00_0_0_0;
            opLui:    ctrl = 13'b0_0_0_0_10_1_1_00_0_0_0;
            opAuipc:  ctrl = 13'b0_0_0_0_01_1_1_00_0_0_0;
            opJal:    ctrl = 13'b0_0_0_0_00_0_1_01_1_0_0;
            opJalr:   ctrl = 13'b0_0_0_0_00_1_1_10_1_0_0;
            opFence:  ctrl = 13'b0;
            opSystem: ctrl = {11'b0_0_0_0_00_0_1_00_0, 1'b1, envCall};
            default:  ctrl = 13'b0_0_0_0_00_0_0_00_0_0_1;
        endcase
        return ctrl;
    endfunction

    function automatic instrT encR(input logic [6:0] f7, input regAddrT rs2,
                                   input regAddrT rs1, input logic [2:0] f3, input regAddrT rdA);
        return {f7, rs2, rs1, f3, rdA, opRType};
    endfunction

    function automatic instrT encI(input wordT immVal, input regAddrT rs1, input logic [2:0] f3,
                                   input regAddrT rdA, input opcodeT op);
        return {immVal[11:0], rs1, f3, rdA, op};
    endfunction

    function automatic instrT encS(input wordT immVal, input regAddrT rs2, input regAddrT rs1,
                                   input logic [2:0] f3);
        return {immVal[11:5], rs2, rs1, f3, immVal[4:0], opStore};
    endfunction

    function automatic instrT encB(input wordT immVal, input regAddrT rs2, input regAddrT rs1,
                                   input logic [2:0] f3);
        return {immVal[12], immVal[10:5], rs2, rs1, f3, immVal[4:1], immVal[11], opBranch};
    endfunction

    function automatic instrT encU(input wordT immVal, input regAddrT rdA, input opcodeT op);
        return {immVal[31:12], rdA, op};
    endfunction

    function automatic instrT encJ(input wordT immVal, input regAddrT rdA);
        return {immVal[20], immVal[10:1], immVal[11], immVal[19:12], rdA, opJal};
    endfunction

    // Called just after a rising edge, returns just after the accept edge
    task automatic offer(input instrT word);
        inValid = 1'b1;
        instr   = word;
        pc      = nextPc;
        @(negedge clk);
        while (!inReady) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        inValid = 1'b0;
        nextPc  = nextPc + 32'd4;
    endtask

    // Offered instruction must go in on the very next edge
    task automatic acceptNow(input instrT word);
        inValid = 1'b1;
        instr   = word;
        pc      = nextPc;
        @(negedge clk);
        checkValue("o_inReady", 32'(inReady), 32'd1);
        @(posedge clk);
        #1;
        inValid = 1'b0;
        nextPc  = nextPc + 32'd4;
    endtask

    task automatic checkDecoded(input instrT word, input aluFuncT expFunc, input wordT expImm);
        checkValue("o_outValid", 32'(outValid), 32'd1);
        checkValue("control bits", 32'(ctrlSeen), 32'(expectedControls(word)));
        checkValue("o_aluFunc", 32'(aluFunc), 32'(expFunc));
        checkValue("o_imm", imm, expImm);
        checkValue("o_rs1Data", rs1Data, regModel[word[19:15]]);
        checkValue("o_rs2Data", rs2Data, regModel[word[24:20]]);
        checkValue("o_rd", 32'(rd), 32'(word[11:7]));
        checkValue("o_pc", pcOut, pc);
    endtask

    task automatic runInstr(input instrT word, input aluFuncT expFunc, input wordT expImm);
        offer(word);
        checkDecoded(word, expFunc, expImm);
    endtask

    task automatic writeReg(input regAddrT addr, input wordT data);
        wbEnable = 1'b1;
        wbAddr   = addr;
        wbData   = data;
        @(posedge clk);
        #1;
        wbEnable = 1'b0;
        if (addr != 5'd0) begin
            regModel[addr] = data; // x0 stays zero
        end
    endtask

    // Dependent instruction waits out exactly one bubble behind the load
    task automatic expectBubble(input instrT load, input instrT user);
        offer(load);
        checkDecoded(load, aluAdd, 32'd0);
        inValid = 1'b1;
        instr   = user;
        pc      = nextPc;
        @(negedge clk);
        checkValue("o_inReady", 32'(inReady), 32'd0);
        @(posedge clk);
        #1;
        checkValue("o_outValid", 32'(outValid), 32'd0); // Bubble
        checkValue("control bits", 32'(ctrlSeen), 32'd0);
        acceptNow(user);
        checkDecoded(user, aluAdd, 32'd0);
    endtask

    task automatic checkReset();
        checkValue("o_outValid", 32'(outValid), 32'd0);
        checkValue("control bits", 32'(ctrlSeen), 32'd0);
        @(negedge clk);
        checkValue("o_inReady", 32'(inReady), 32'd1);
        @(posedge clk);
        #1;
    endtask

    task automatic testOpcodes();
        runInstr(encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), aluAdd, 32'd0);
        runInstr(encI(32'd100, 5'd1, 3'b000, 5'd4, opIType), aluAdd, 32'd100);
        runInstr(encI(-32'd8, 5'd2, 3'b010, 5'd5, opLoad), aluAdd, -32'd8);
        runInstr(encS(-32'd12, 5'd3, 5'd2, 3'b010), aluAdd, -32'd12);
        runInstr(encB(-32'd16, 5'd2, 5'd1, 3'b000), aluBeq, -32'd16);
        runInstr(encU(32'hABCDE000, 5'd6, opLui), aluAdd, 32'hABCDE000);
        runInstr(encU(32'h12345000, 5'd7, opAuipc), aluAdd, 32'h12345000);
        runInstr(encJ(32'd2048, 5'd1), aluAdd, 32'd2048);
        runInstr(encJ(-32'd1048576, 5'd0), aluAdd, -32'd1048576);
        runInstr(encI(-32'd4, 5'd1, 3'b000, 5'd0, opJalr), aluAdd, -32'd4);
        runInstr(32'h0FF0000F, aluAdd, 32'd0); // FENCE
    endtask

    task automatic testAluFunctions();
        aluFuncT    regFuncs [8] = '{aluAdd, aluSll, aluSlt, aluSltu, aluXor, aluSrl, aluOr, aluAnd};
        logic [2:0] branchF3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        aluFuncT    branchFuncs [6] = '{aluBeq, aluBne, aluBlt, aluBge, aluBltu, aluBgeu};
        wordT       offset;
        for (int f = 0; f < 8; f++) begin
            runInstr(encR(7'h00, 5'd2, 5'd1, 3'(f), 5'd3), regFuncs[f], 32'd0);
        end
        runInstr(encR(7'h20, 5'd2, 5'd1, 3'b000, 5'd3), aluSub, 32'd0);
        runInstr(encR(7'h20, 5'd2, 5'd1, 3'b101, 5'd3), aluSra, 32'd0);
        runInstr(encI(32'h400, 5'd1, 3'b000, 5'd4, opIType), aluAdd, 32'h400); // Bit 30 set
        runInstr(encI(32'h405, 5'd1, 3'b101, 5'd4, opIType), aluSra, 32'h405);
        for (int b = 0; b < 6; b++) begin
            offset = (b % 2 == 0) ? -32'd4096 : 32'd4094;
            runInstr(encB(offset, 5'd2, 5'd1, branchF3[b]), branchFuncs[b], offset);
        end
        runInstr(encI(32'd2047, 5'd1, 3'b010, 5'd8, opLoad), aluAdd, 32'd2047);
        runInstr(encS(-32'd2048, 5'd2, 5'd1, 3'b010), aluAdd, -32'd2048);
        runInstr(encU(32'hFFFFF000, 5'd9, opLui), aluAdd, 32'hFFFFF000);
        runInstr(encI(32'd16, 5'd1, 3'b000, 5'd1, opJalr), aluAdd, 32'd16);
    endtask

    task automatic testRegisterFile();
        wordT  data;
        instrT word;
        for (int r = 1; r < 32; r++) begin
            data = $random(seed);
            writeReg(5'(r), data);
        end
        for (int r = 1; r < 32; r += 2) begin
            runInstr(encR(7'h00, 5'(r + 1), 5'(r), 3'b000, 5'd3), aluAdd, 32'd0);
        end
        writeReg(5'd0, 32'hDEADBEEF);
        runInstr(encR(7'h00, 5'd0, 5'd0, 3'b000, 5'd1), aluAdd, 32'd0);
        // A bypassed write to x0 still reads zero
        word     = encR(7'h00, 5'd0, 5'd0, 3'b000, 5'd1);
        wbEnable = 1'b1;
        wbAddr   = 5'd0;
        wbData   = 32'hDEADBEEF;
        offer(word);
        wbEnable = 1'b0;
        checkDecoded(word, aluAdd, 32'd0);
        // Write lands on the same edge that accepts the reader
        data     = $random(seed);
        wbEnable = 1'b1;
        wbAddr   = 5'd10;
        wbData   = data;
        word     = encR(7'h00, 5'd10, 5'd10, 3'b000, 5'd3);
        offer(word);
        wbEnable     = 1'b0;
        regModel[10] = data;
        checkDecoded(word, aluAdd, 32'd0);
    endtask

    task automatic testExceptions();
        runInstr(32'h00000073, aluAdd, 32'd0); // ECALL
        runInstr(32'h00100073, aluAdd, 32'd0); // EBREAK
        runInstr(encI(32'h300, 5'd2, 3'b001, 5'd1, opSystem), aluAdd, 32'd0);
        runInstr(32'h0000007F, aluAdd, 32'd0);
    endtask

    task automatic testBackPressure();
        instrT first;
        instrT second;
        wordT  firstPc;
        first  = encI(32'd1, 5'd1, 3'b000, 5'd11, opIType);
        second = encI(32'd2, 5'd1, 3'b000, 5'd12, opIType);
        offer(first);
        outReady = 1'b0;
        checkDecoded(first, aluAdd, 32'd1);
        firstPc = pc;
        inValid = 1'b1;
        instr   = second;
        pc      = nextPc;
        repeat (3) begin
            @(negedge clk);
            checkValue("o_inReady", 32'(inReady), 32'd0);
            @(posedge clk);
            #1;
            checkValue("o_outValid", 32'(outValid), 32'd1);
            checkValue("control bits", 32'(ctrlSeen), 32'(expectedControls(first)));
            checkValue("o_imm", imm, 32'd1);
            checkValue("o_pc", pcOut, firstPc);
        end
        outReady = 1'b1;
        offer(second);
        checkDecoded(second, aluAdd, 32'd2);
    endtask

    task automatic testLoadUse();
        instrT load;
        instrT user;
        // Dependence through rs2, then through rs1
        expectBubble(encI(32'd0, 5'd1, 3'b010, 5'd13, opLoad),
                     encR(7'h00, 5'd13, 5'd2, 3'b000, 5'd14));
        expectBubble(encI(32'd0, 5'd1, 3'b010, 5'd16, opLoad),
                     encR(7'h00, 5'd2, 5'd16, 3'b000, 5'd17));
        load = encI(32'd0, 5'd1, 3'b010, 5'd0, opLoad);
        user = encR(7'h00, 5'd0, 5'd0, 3'b000, 5'd15);
        offer(load);
        checkDecoded(load, aluAdd, 32'd0);
        acceptNow(user); // x0 never stalls
        checkDecoded(user, aluAdd, 32'd0);
    endtask

    initial begin
        reset    = 1'b1;
        inValid  = 1'b0;
        instr    = '0;
        pc       = '0;
        outReady = 1'b1;
        wbEnable = 1'b0;
        wbAddr   = '0;
        wbData   = '0;
        nextPc   = 32'h0000_1000;
        for (int r = 0; r < 32; r++) begin
            regModel[r] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        checkReset();
        testOpcodes();
        testAluFunctions();
        testRegisterFile();
        testExceptions();
        testBackPressure();
        testLoadUse();
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- verilog/aluControl.sv
`timescale 1ns/10ps

module aluControl (
    input  rvDecodePkg::aluOpT   i_aluOp,
    input  logic [2:0]           i_funct3,
    input  logic                 i_funct7b5,
    output rvDecodePkg::aluFuncT o_aluFunc
);
    import rvDecodePkg::*;

    aluFuncT opFunc;
    logic    isImm;

    assign isImm = (i_aluOp == aluOpImm);

    // Shared by register and immediate forms
    always_comb begin
        case (i_funct3)
            3'b000:  opFunc = (i_funct7b5 && !isImm) ? aluSub : aluAdd; // No SUBI
            3'b001:  opFunc = aluSll;
            3'b010:  opFunc = aluSlt;
            3'b011:  opFunc = aluSltu;
            3'b100:  opFunc = aluXor;
            3'b101:  opFunc = i_funct7b5 ? aluSra : aluSrl;
            3'b110:  opFunc = aluOr;
            default: opFunc = aluAnd;
        endcase
    end

    always_comb begin
        case (i_aluOp)
            aluOpReg,
            aluOpImm:    o_aluFunc = opFunc;
            aluOpBranch: begin
                case (i_funct3)
                    3'b000:  o_aluFunc = aluBeq;
                    3'b001:  o_aluFunc = aluBne;
                    3'b100:  o_aluFunc = aluBlt;
                    3'b101:  o_aluFunc = aluBge;
                    3'b110:  o_aluFunc = aluBltu;
                    3'b111:  o_aluFunc = aluBgeu;
                    default: o_aluFunc = aluAdd;
                endcase
            end
            default:     o_aluFunc = aluAdd; // Add and Pass
        endcase
    end

endmodule

//--- verilog/decodeTop.sv
`timescale 1ns/10ps

module decodeTop #(
    parameter int regCount = 32
) (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_inValid,
    input  rvDecodePkg::instrT   i_instr,
    input  rvDecodePkg::wordT    i_pc,
    output logic                 o_inReady,
    input  logic                 i_outReady,
    input  logic                 i_wbEnable,
    input  rvDecodePkg::regAddrT i_wbAddr,
    input  rvDecodePkg::wordT    i_wbData,
    output logic                 o_outValid,
    output logic                 o_branch,
    output logic                 o_memRead,
    output logic                 o_memWrite,
    output logic                 o_memToReg,
    output logic [1:0]           o_aluSrcA,
    output logic                 o_aluSrcB,
    output logic                 o_regWrite,
    output logic [1:0]           o_jump,
    output logic                 o_pcPlus4,
    output logic                 o_csrEnable,
    output logic                 o_exception,
    output rvDecodePkg::aluFuncT o_aluFunc,
    output rvDecodePkg::wordT    o_imm,
    output rvDecodePkg::wordT    o_rs1Data,
    output rvDecodePkg::wordT    o_rs2Data,
    output rvDecodePkg::regAddrT o_rd,
    output rvDecodePkg::wordT    o_pc
);
    import rvDecodePkg::*;

    logic       stall;
    logic       branch;
    logic       memRead;
    logic       memWrite;
    logic       memToReg;
    aluOpT      aluOp;
    logic [1:0] aluSrcA;
    logic       aluSrcB;
    logic       regWrite;
    logic [1:0] jump;
    logic       pcPlus4;
    logic       csrEnable;
    logic       exception;
    aluFuncT    aluFunc;
    wordT       imm;
    wordT       rs1Data;
    wordT       rs2Data;

    mainControl i_mainControl (
        .i_instr(i_instr), .i_stall(stall),
        .o_branch(branch), .o_memRead(memRead), .o_memWrite(memWrite),
        .o_memToReg(memToReg), .o_aluOp(aluOp), .o_aluSrcA(aluSrcA),
        .o_aluSrcB(aluSrcB), .o_regWrite(regWrite), .o_jump(jump),
        .o_pcPlus4(pcPlus4), .o_csrEnable(csrEnable), .o_exception(exception)
    );

    aluControl i_aluControl (
        .i_aluOp(aluOp), .i_funct3(i_instr[14:12]), .i_funct7b5(i_instr[30]),
        .o_aluFunc(aluFunc)
    );

    immediateGen i_immediateGen (
        .i_instr(i_instr), .o_imm(imm)
    );

    registerFile #(.regCount(regCount)) i_registerFile (
        .i_clk(i_clk), .i_reset(i_reset),
        .i_rs1Addr(i_instr[19:15]), .i_rs2Addr(i_instr[24:20]),
        .i_wbEnable(i_wbEnable), .i_wbAddr(i_wbAddr), .i_wbData(i_wbData),
        .o_rs1Data(rs1Data), .o_rs2Data(rs2Data)
    );

    idExStage i_idExStage (
        .i_clk(i_clk), .i_reset(i_reset), .i_inValid(i_inValid), .i_outReady(i_outReady),
        .i_rs1Addr(i_instr[19:15]), .i_rs2Addr(i_instr[24:20]), .i_rdAddr(i_instr[11:7]),
        .i_pc(i_pc), .i_branch(branch), .i_memRead(memRead), .i_memWrite(memWrite),
        .i_memToReg(memToReg), .i_aluSrcA(aluSrcA), .i_aluSrcB(aluSrcB),
        .i_regWrite(regWrite), .i_jump(jump), .i_pcPlus4(pcPlus4),
        .i_csrEnable(csrEnable), .i_exception(exception), .i_aluFunc(aluFunc),
        .i_imm(imm), .i_rs1Data(rs1Data), .i_rs2Data(rs2Data),
        .o_inReady(o_inReady), .o_stall(stall), .o_outValid(o_outValid),
        .o_branch(o_branch), .o_memRead(o_memRead), .o_memWrite(o_memWrite),
        .o_memToReg(o_memToReg), .o_aluSrcA(o_aluSrcA), .o_aluSrcB(o_aluSrcB),
        .o_regWrite(o_regWrite), .o_jump(o_jump), .o_pcPlus4(o_pcPlus4),
        .o_csrEnable(o_csrEnable), .o_exception(o_exception), .o_aluFunc(o_aluFunc),
        .o_imm(o_imm), .o_rs1Data(o_rs1Data), .o_rs2Data(o_rs2Data),
        .o_rd(o_rd), .o_pc(o_pc)
    );

endmodule

//--- verilog/idExStage.sv
`timescale 1ns/10ps

module idExStage (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_inValid,
    input  logic                 i_outReady,
    input  rvDecodePkg::regAddrT i_rs1Addr,
    input  rvDecodePkg::regAddrT i_rs2Addr,
    input  rvDecodePkg::regAddrT i_rdAddr,
    input  rvDecodePkg::wordT    i_pc,
    input  logic                 i_branch,
    input  logic                 i_memRead,
    input  logic                 i_memWrite,
    input  logic                 i_memToReg,
    input  logic [1:0]           i_aluSrcA,
    input  logic                 i_aluSrcB,
    input  logic                 i_regWrite,
    input  logic [1:0]           i_jump,
    input  logic                 i_pcPlus4,
    input  logic                 i_csrEnable,
    input  logic                 i_exception,
    input  rvDecodePkg::aluFuncT i_aluFunc,
    input  rvDecodePkg::wordT    i_imm,
    input  rvDecodePkg::wordT    i_rs1Data,
    input  rvDecodePkg::wordT    i_rs2Data,
    output logic                 o_inReady,
    output logic                 o_stall,
    output logic                 o_outValid,
    output logic                 o_branch,
    output logic                 o_memRead,
    output logic                 o_memWrite,
    output logic                 o_memToReg,
    output logic [1:0]           o_aluSrcA,
    output logic                 o_aluSrcB,
    output logic                 o_regWrite,
    output logic [1:0]           o_jump,
    output logic                 o_pcPlus4,
    output logic                 o_csrEnable,
    output logic                 o_exception,
    output rvDecodePkg::aluFuncT o_aluFunc,
    output rvDecodePkg::wordT    o_imm,
    output rvDecodePkg::wordT    o_rs1Data,
    output rvDecodePkg::wordT    o_rs2Data,
    output rvDecodePkg::regAddrT o_rd,
    output rvDecodePkg::wordT    o_pc
);
    import rvDecodePkg::*;

    // 13 control bits plus function, four words and rd
    localparam int payloadWidth = 13 + $bits(aluFuncT) + 4 * $bits(wordT) + $bits(regAddrT);

    logic                    validQ;
    logic                    hazard;
    logic                    loadEnable;
    logic                    accept;
    logic [payloadWidth-1:0] payloadIn;
    logic [payloadWidth-1:0] payloadQ;

    // Held load writes a register the incoming instruction reads
    assign hazard = validQ && o_memRead && (o_rd != '0) &&
                    (o_rd == i_rs1Addr || o_rd == i_rs2Addr);

    assign loadEnable = !validQ || i_outReady; // Empty or draining
    assign o_inReady  = loadEnable && !hazard;
    assign o_stall    = hazard;
    assign accept     = i_inValid && o_inReady;
    assign o_outValid = validQ;

    assign payloadIn = {i_branch, i_memRead, i_memWrite, i_memToReg, i_aluSrcA, i_aluSrcB,
                        i_regWrite, i_jump, i_pcPlus4, i_csrEnable, i_exception, i_aluFunc,
                        i_imm, i_rs1Data, i_rs2Data, i_rdAddr, i_pc};

    assign {o_branch, o_memRead, o_memWrite, o_memToReg, o_aluSrcA, o_aluSrcB,
            o_regWrite, o_jump, o_pcPlus4, o_csrEnable, o_exception, o_aluFunc,
            o_imm, o_rs1Data, o_rs2Data, o_rd, o_pc} = payloadQ;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            validQ   <= 1'b0;
            payloadQ <= '0;
        end else if (loadEnable) begin
            validQ   <= accept;
            payloadQ <= accept ? payloadIn : '0; // Bubble or empty reads as zero
        end
    end

endmodule

//--- verilog/immediateGen.sv
`timescale 1ns/10ps

module immediateGen (
    input  rvDecodePkg::instrT i_instr,
    output rvDecodePkg::wordT  o_imm
);
    import rvDecodePkg::*;

    opcodeT opcode;
    logic   sign;

    assign opcode = i_instr[6:0];
    assign sign   = i_instr[31];

    always_comb begin
        case (opcode)
            opIType, opLoad, opJalr: begin
                o_imm = {{20{sign}}, i_instr[31:20]};
            end
            opStore: begin
                o_imm = {{20{sign}}, i_instr[31:25], i_instr[11:7]};
            end
            opBranch: begin
                o_imm = {{20{sign}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
            end
            opLui, opAuipc: begin
                o_imm = {i_instr[31:12], 12'd0}; // Upper 20 bits
            end
            opJal: begin
                o_imm = {{12{sign}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
            end
            default: begin
                o_imm = '0;
            end
        endcase
    end

endmodule

//--- verilog/mainControl.sv
`timescale 1ns/10ps

module mainControl (
    input  rvDecodePkg::instrT i_instr,
    input  logic               i_stall,
    output logic               o_branch,
    output logic               o_memRead,
    output logic               o_memWrite,
    output logic               o_memToReg,
    output rvDecodePkg::aluOpT o_aluOp,
    output logic [1:0]         o_aluSrcA,
    output logic               o_aluSrcB,
    output logic               o_regWrite,
    output logic [1:0]         o_jump,
    output logic               o_pcPlus4,
    output logic               o_csrEnable,
    output logic               o_exception
);
    import rvDecodePkg::*;

    opcodeT opcode;
    logic   isEnvCall;

    assign opcode = i_instr[6:0];

    // ECALL is 12'h000, EBREAK is 12'h001
    assign isEnvCall = (i_instr[14:12] == 3'b000) && (i_instr[19:15] == 5'd0) &&
                       (i_instr[11:7] == 5'd0) &&
                       (i_instr[31:20] == 12'h000 || i_instr[31:20] == 12'h001);

    always_comb begin
        o_branch    = 1'b0;
        o_memRead   = 1'b0;
        o_memWrite  = 1'b0;
        o_memToReg  = 1'b0;
        o_aluOp     = aluOpAdd;
        o_aluSrcA   = 2'd0;
        o_aluSrcB   = 1'b0;
        o_regWrite  = 1'b0;
        o_jump      = 2'd0;
        o_pcPlus4   = 1'b0;
        o_csrEnable = 1'b0;
        o_exception = 1'b0;
        if (!i_stall) begin // Bubble keeps everything low
            case (opcode)
                opRType: begin
                    o_regWrite = 1'b1;
                    o_aluOp    = aluOpReg;
                end
                opIType: begin
                    o_aluSrcB  = 1'b1;
                    o_regWrite = 1'b1;
                    o_aluOp    = aluOpImm;
                end
                opLoad: begin
                    o_memRead  = 1'b1;
                    o_memToReg = 1'b1;
                    o_aluSrcB  = 1'b1;
                    o_regWrite = 1'b1;
                end
                opStore: begin
                    o_memWrite = 1'b1;
                    o_aluSrcB  = 1'b1;
                end
                opBranch: begin
                    o_branch = 1'b1;
                    o_aluOp  = aluOpBranch;
                end
                opLui: begin
                    o_aluSrcA  = 2'd2; // Zero plus immediate
                    o_aluSrcB  = 1'b1;
                    o_regWrite = 1'b1;
                    o_aluOp    = aluOpPass;
                end
                opAuipc: begin
                    o_aluSrcA  = 2'd1; // PC plus immediate
                    o_aluSrcB  = 1'b1;
                    o_regWrite = 1'b1;
                    o_aluOp    = aluOpPass;
                end
                opJal: begin
                    o_regWrite = 1'b1;
                    o_jump     = 2'd1;
                    o_pcPlus4  = 1'b1;
                end
                opJalr: begin
                    o_aluSrcB  = 1'b1;
                    o_regWrite = 1'b1;
                    o_aluOp    = aluOpPass;
                    o_jump     = 2'd2;
                    o_pcPlus4  = 1'b1;
                end
                opFence: begin
                    o_regWrite = 1'b0; // Treated as NOP
                end
                opSystem: begin
                    o_regWrite  = 1'b1;
                    o_csrEnable = 1'b1;
                    o_exception = isEnvCall;
                end
                default: begin
                    o_exception = 1'b1; // Illegal opcode
                end
            endcase
        end
    end

endmodule

//--- verilog/registerFile.sv
`timescale 1ns/10ps

module registerFile #(
    parameter int regCount = 32
) (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  rvDecodePkg::regAddrT i_rs1Addr,
    input  rvDecodePkg::regAddrT i_rs2Addr,
    input  logic                 i_wbEnable,
    input  rvDecodePkg::regAddrT i_wbAddr,
    input  rvDecodePkg::wordT    i_wbData,
    output rvDecodePkg::wordT    o_rs1Data,
    output rvDecodePkg::wordT    o_rs2Data
);
    import rvDecodePkg::*;

    wordT regs [regCount];

    // Zero for x0 and unimplemented registers
    function automatic wordT readPort(input regAddrT addr);
        wordT value;
        if (addr == '0 || addr >= regCount) begin
            value = '0;
        end else if (i_wbEnable && i_wbAddr == addr) begin
            value = i_wbData; // Write-through
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wbEnable && i_wbAddr != '0 && i_wbAddr < regCount) begin
            regs[i_wbAddr] <= i_wbData;
        end
    end

    always_comb begin
        o_rs1Data = readPort(i_rs1Addr);
        o_rs2Data = readPort(i_rs2Addr);
    end

endmodule

//--- verilog/rvDecodePkg.sv
package rvDecodePkg;

    typedef logic [31:0] instrT;
    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;
    typedef logic [6:0]  opcodeT;
    typedef logic [2:0]  aluOpT;
    typedef logic [3:0]  aluFuncT;

    // RV32I major opcodes
    localparam opcodeT opRType  = 7'b0110011;
    localparam opcodeT opIType  = 7'b0010011;
    localparam opcodeT opLoad   = 7'b0000011;
    localparam opcodeT opStore  = 7'b0100011;
    localparam opcodeT opBranch = 7'b1100011;
    localparam opcodeT opLui    = 7'b0110111;
    localparam opcodeT opAuipc  = 7'b0010111;
    localparam opcodeT opJal    = 7'b1101111;
    localparam opcodeT opJalr   = 7'b1100111;
    localparam opcodeT opSystem = 7'b1110011;
    localparam opcodeT opFence  = 7'b0001111;

    localparam aluOpT aluOpAdd    = 3'd0;
    localparam aluOpT aluOpBranch = 3'd1;
    localparam aluOpT aluOpReg    = 3'd2;
    localparam aluOpT aluOpImm    = 3'd3;
    localparam aluOpT aluOpPass   = 3'd4; // LUI, AUIPC, JALR

    localparam aluFuncT aluAdd  = 4'd0;
    localparam aluFuncT aluSub  = 4'd1;
    localparam aluFuncT aluSll  = 4'd2;
    localparam aluFuncT aluSlt  = 4'd3;
    localparam aluFuncT aluSltu = 4'd4;
    localparam aluFuncT aluXor  = 4'd5;
    localparam aluFuncT aluSrl  = 4'd6;
    localparam aluFuncT aluSra  = 4'd7;
    localparam aluFuncT aluOr   = 4'd8;
    localparam aluFuncT aluAnd  = 4'd9;
    localparam aluFuncT aluBeq  = 4'd10; // Branch compares
    localparam aluFuncT aluBne  = 4'd11;
    localparam aluFuncT aluBlt  = 4'd12;
    localparam aluFuncT aluBge  = 4'd13;
    localparam aluFuncT aluBltu = 4'd14;
    localparam aluFuncT aluBgeu = 4'd15;

endpackage
